//--- list.f
+incdir+.
rapid_pkg.sv
ex_operand_if.sv
int_alu.sv
branch_unit.sv
ex_sequencer.sv
execute_stage.sv
tb_execute_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_execute_stage -f list.f &&
./obj_dir/Vtb_execute_stage | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- tb_execute_stage.sv
`include "rv_macros.svh"

module tb_execute_stage;

    import rapid_pkg::*;

    // 50 instructions at 3 cycles each plus a margin
    localparam int N_INSTR     = 50;
    localparam int CYCLE_LIMIT = 3 * N_INSTR + 50;
    localparam int DONE_WAIT   = 4;

    // Category one-hot patterns with load_upper_imm in the top bit
    localparam logic [5:0] CAT_UPPER = 6'b100000;
    localparam logic [5:0] CAT_JUMP  = 6'b010000;
    localparam logic [5:0] CAT_BR    = 6'b001000;
    localparam logic [5:0] CAT_MEM   = 6'b000100;
    localparam logic [5:0] CAT_IMM   = 6'b000010;
    localparam logic [5:0] CAT_REG   = 6'b000001;

    logic               i_clk;
    logic               i_reset;
    logic               i_pipeline_ready;
    logic [`XLEN_W-1:0] i_pc;
    logic [`XLEN_W-1:0] i_rs1;
    logic [`XLEN_W-1:0] i_rs2;
    logic [`XLEN_W-1:0] i_imm;
    control_s           i_control_signal;
    control_s           o_control_signal;
    logic [`XLEN_W-1:0] o_pc_ext;
    logic               o_pc_load;
    logic [`XLEN_W-1:0] o_rd_output;
    logic               o_done;
    int                 error_count = 0;
    int                 check_count = 0;
    int                 cycle_count = 0;

    execute_stage execute_stage_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .i_pc             (i_pc),
        .i_control_signal (i_control_signal),
        .i_rs1            (i_rs1),
        .i_rs2            (i_rs2),
        .i_imm            (i_imm),
        .o_control_signal (o_control_signal),
        .o_pc_ext         (o_pc_ext),
        .o_pc_load        (o_pc_load),
        .o_rd_output      (o_rd_output),
        .o_done           (o_done)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    // A stuck DUT ends the run at the cycle limit
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic void predict_outputs(input control_s c, input logic [31:0] pc,
                                            input logic [31:0] rs1, input logic [31:0] rs2,
                                            input logic [31:0] imm, output logic [31:0] rd,
                                            output logic [31:0] pc_next, output logic load);
        logic [31:0] b;
        logic        taken;
        b  = c.alu_reg ? rs2 : imm;
        rd = '0;
        if (c.alu_reg || c.alu_imm) begin
            case (c.fcs_opcode)
                3'd0: rd = c.iop ? rs1 - b : rs1 + b;
                3'd1: rd = rs1 << b[4:0];
                3'd2: rd = {31'd0, $signed(rs1) < $signed(b)};
                3'd3: rd = {31'd0, rs1 < b};
                3'd4: rd = rs1 ^ b;
                // SRA fills the vacated top bits with the sign
                3'd5: begin
                    rd = rs1 >> b[4:0];
                    if (c.iop && rs1[31]) begin
                        rd = rd | ~(32'hffff_ffff >> b[4:0]);
                    end
                end
                3'd6: rd = rs1 | b;
                default: rd = rs1 & b;
            endcase
        end else if (c.load_upper_imm) begin
            rd = c.iop ? imm : pc + imm;
        end else if (c.mem) begin
            rd = rs1 + imm;
        end else if (c.uncond_branch) begin
            rd = pc + `XLEN_W'(`PC_STEP);
        end
        case (c.fcs_opcode)
            BR_BEQ:  taken = (rs1 == rs2);
            BR_BNE:  taken = (rs1 != rs2);
            BR_BLT:  taken = ($signed(rs1) < $signed(rs2));
            BR_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: taken = (rs1 < rs2);
            BR_BGEU: taken = (rs1 >= rs2);
            default: taken = 1'b0;
        endcase
        load    = c.uncond_branch || (c.cond_branch && taken);
        pc_next = load ? pc + imm : pc + `XLEN_W'(`PC_STEP);
        // JALR is register relative with bit 0 dropped
        if (c.uncond_branch && c.fcs_opcode == BR_JALR) begin
            pc_next = (rs1 + imm) & ~32'd1;
        end
    endfunction

    //////////////////////////////////////////////////
    // Drive and check helpers
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic set_inputs(input control_s c, input logic [31:0] pc, input logic [31:0] rs1,
                              input logic [31:0] rs2, input logic [31:0] imm);
        i_control_signal = c;
        i_pc  = pc;
        i_rs1 = rs1;
        i_rs2 = rs2;
        i_imm = imm;
    endtask

    task automatic check_outputs(input control_s c, input logic [31:0] pc,
                                 input logic [31:0] rs1, input logic [31:0] rs2,
                                 input logic [31:0] imm);
        logic [31:0] rd;
        logic [31:0] pc_next;
        logic        load;
        predict_outputs(c, pc, rs1, rs2, imm, rd, pc_next, load);
        check_word("o_rd_output", rd, o_rd_output);
        check_word("o_pc_ext", pc_next, o_pc_ext);
        check_word("o_pc_load", {31'd0, load}, {31'd0, o_pc_load});
        check_word("o_control_signal", {21'd0, c}, {21'd0, o_control_signal});
    endtask

    // Counts the edges until done shows and samples 1 unit after each
    task automatic wait_for_done(output int cycles);
        int n;
        n = 0;
        while (!o_done && n < DONE_WAIT) begin
            @(posedge i_clk);
            #1;
            n++;
        end
        cycles = n;
        assert (o_done) else begin
            $display("o_done did not rise within %0d cycles of the capture edge", DONE_WAIT);
            error_count++;
        end
    endtask

    // Done belongs on the edge right after the capture edge
    task automatic check_done_delay(input int n);
        assert (n == 1) else begin
            $display("o_done came %0d cycles after the capture edge instead of 1", n);
            error_count++;
        end
    endtask

    task automatic drive_and_check(input logic [5:0] cat, input logic [2:0] fn, input logic iop,
                                   input logic [31:0] pc, input logic [31:0] rs1,
                                   input logic [31:0] rs2, input logic [31:0] imm);
        control_s c;
        int       n;
        c = control_s'({cat, fn, iop, 1'b0});
        set_inputs(c, pc, rs1, rs2, imm);
        i_pipeline_ready = 1'b1;
        @(posedge i_clk);
        #1;
        i_pipeline_ready = 1'b0;
        wait_for_done(n);
        if (o_done) begin
            check_done_delay(n);
            check_outputs(c, pc, rs1, rs2, imm);
        end
    endtask

    task automatic report_result(input string name, input int start);
        $display("%s: %0d errors", name, error_count - start);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic check_after_reset();
        int start;
        start = error_count;
        check_word("o_done", 32'd0, {31'd0, o_done});
        check_word("o_pc_load", 32'd0, {31'd0, o_pc_load});
        check_word("o_rd_output", 32'd0, o_rd_output);
        check_word("o_pc_ext", 32'd0, o_pc_ext);
        check_word("o_control_signal", 32'd0, {21'd0, o_control_signal});
        report_result("after reset", start);
    endtask

    task automatic exercise_alu();
        int form;
        int i;
        int start;
        start = error_count;
        // Eight plain codes and then SUB and SRA through iop
        for (form = 0; form < 2; form++) begin
            for (i = 0; i < 10; i++) begin
                drive_and_check(form == 0 ? CAT_REG : CAT_IMM,
                                (i < 8) ? i[2:0] : ((i == 8) ? 3'd0 : 3'd5), i >= 8,
                                $urandom & 32'hffff_fffc, $urandom, $urandom, $urandom);
            end
        end
        // Negative against positive splits SLT from SLTU
        drive_and_check(CAT_REG, ALU_SLT, 1'b0, 32'h40, 32'hffff_fffb, 32'h3, 32'h0);
        drive_and_check(CAT_REG, ALU_SLTU, 1'b0, 32'h44, 32'hffff_fffb, 32'h3, 32'h0);
        // Negative rs1 makes SRA fill with ones where SRL fills with zeros
        drive_and_check(CAT_REG, ALU_SRL_SRA, 1'b1, 32'h48, 32'h8000_00f0, 32'h4, 32'h0);
        report_result("alu ops", start);
    endtask

    task automatic upper_imm_and_mem();
        int start;
        start = error_count;
        // LUI then AUIPC
        drive_and_check(CAT_UPPER, 3'd0, 1'b1, 32'h1000, $urandom, $urandom, 32'habcd_e000);
        drive_and_check(CAT_UPPER, 3'd0, 1'b0, 32'h1004, $urandom, $urandom, 32'h0001_2000);
        // Load with a negative offset and then a store
        drive_and_check(CAT_MEM, 3'd2, 1'b0, 32'h1008, 32'h8000_0100, $urandom, 32'hffff_fff8);
        drive_and_check(CAT_MEM, 3'd2, 1'b1, 32'h100c, 32'h0000_2000, $urandom, 32'h0000_0010);
        report_result("upper imm and mem", start);
    endtask

    task automatic cond_branch_sweep();
        logic [31:0] neg_val;
        logic [31:0] pos_val;
        logic [2:0]  fn;
        int          i;
        int          p;
        int          start;
        start   = error_count;
        neg_val = 32'hffff_fff0;
        pos_val = 32'h0000_0010;
        // Pairs neg/pos, pos/neg and equal give each code both outcomes
        for (i = 0; i < 6; i++) begin
            fn = (i < 2) ? i[2:0] : 3'(i + 2);
            for (p = 0; p < 3; p++) begin
                drive_and_check(CAT_BR, fn, 1'b0, $urandom & 32'hffff_fffc,
                                (p == 0) ? neg_val : pos_val, (p == 1) ? neg_val : pos_val,
                                p[0] ? 32'hffff_ffe0 : 32'h0000_0040);
            end
        end
        report_result("cond branches", start);
    endtask

    task automatic jump_targets();
        int start;
        start = error_count;
        drive_and_check(CAT_JUMP, BR_JAL, 1'b0, 32'h0000_2000, $urandom, $urandom, 32'hffff_f800);
        // Odd rs1 plus imm leaves a low bit that must clear
        drive_and_check(CAT_JUMP, BR_JALR, 1'b0, 32'h0000_3000, 32'h0000_4001, $urandom,
                        32'h0000_0010);
        drive_and_check(CAT_JUMP, BR_JALR, 1'b0, 32'h0000_3004, 32'h0000_5000, $urandom,
                        32'hffff_fffc);
        report_result("jumps", start);
    endtask

    task automatic strobe_timing();
        control_s a;
        control_s b;
        int       n;
        int       start;
        start = error_count;
        a = control_s'({CAT_REG, ALU_XOR, 2'b00});
        b = control_s'({CAT_IMM, ALU_ADD_SUB, 2'b00});
        set_inputs(a, 32'h100, 32'h0f0f_1234, 32'hff00_00ff, 32'h0);
        i_pipeline_ready = 1'b1;
        @(posedge i_clk);
        #1;
        // Ready stays high in execute with b on the inputs
        set_inputs(b, 32'h200, 32'h0000_0010, 32'h0, 32'h0000_0020);
        wait_for_done(n);
        check_done_delay(n);
        check_outputs(a, 32'h100, 32'h0f0f_1234, 32'hff00_00ff, 32'h0);
        // Ready is still high on this edge so b is captured
        @(posedge i_clk);
        #1;
        i_pipeline_ready = 1'b0;
        assert (!o_done) else begin
            $display("o_done stayed high longer than one cycle");
            error_count++;
        end
        wait_for_done(n);
        check_outputs(b, 32'h200, 32'h0000_0010, 32'h0, 32'h0000_0020);
        report_result("strobe timing", start);
    endtask

    initial begin
        void'($urandom(32'h2c7fb2b5));
        i_reset          = 1'b1;
        i_pipeline_ready = 1'b0;
        i_control_signal = '0;
        i_pc             = '0;
        i_rs1            = '0;
        i_rs2            = '0;
        i_imm            = '0;
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_after_reset();
        exercise_alu();
        upper_imm_and_mem();
        cond_branch_sweep();
        jump_targets();
        strobe_timing();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- execute_stage.sv
`include "rv_macros.svh"

module execute_stage (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_pipeline_ready,
    input  logic [`XLEN_W-1:0]       i_pc,
    input  rapid_pkg::control_s      i_control_signal,
    input  logic [`XLEN_W-1:0]       i_rs1,
    input  logic [`XLEN_W-1:0]       i_rs2,
    input  logic [`XLEN_W-1:0]       i_imm,
    output rapid_pkg::control_s      o_control_signal,
    output logic [`XLEN_W-1:0]       o_pc_ext,
    output logic                     o_pc_load,
    output logic [`XLEN_W-1:0]       o_rd_output,
    output logic                     o_done
);

    // Unit results back to the sequencer
    logic [`XLEN_W-1:0] alu_result;
    logic [`XLEN_W-1:0] pc_next;
    logic [`XLEN_W-1:0] link;
    logic               pc_load;

    // Captured instruction bus
    ex_operand_if op_if ();

    ex_sequencer ex_sequencer_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .i_pc             (i_pc),
        .i_rs1            (i_rs1),
        .i_rs2            (i_rs2),
        .i_imm            (i_imm),
        .i_control_signal (i_control_signal),
        .io_op            (op_if.source),
        .i_alu_result     (alu_result),
        .i_pc_next        (pc_next),
        .i_link           (link),
        .i_pc_load        (pc_load),
        .o_control_signal (o_control_signal),
        .o_rd_output      (o_rd_output),
        .o_pc_ext         (o_pc_ext),
        .o_pc_load        (o_pc_load),
        .o_done           (o_done)
    );

    // Integer path and pc path work side by side
    int_alu int_alu_i (
        .io_op    (op_if.unit),
        .o_result (alu_result)
    );

    branch_unit branch_unit_i (
        .io_op     (op_if.unit),
        .o_pc_next (pc_next),
        .o_pc_load (pc_load),
        .o_link    (link)
    );

endmodule

//--- ex_sequencer.sv
`include "rv_macros.svh"

module ex_sequencer (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_pipeline_ready,
    input  logic [`XLEN_W-1:0]       i_pc,
    input  logic [`XLEN_W-1:0]       i_rs1,
    input  logic [`XLEN_W-1:0]       i_rs2,
    input  logic [`XLEN_W-1:0]       i_imm,
    input  rapid_pkg::control_s      i_control_signal,
    ex_operand_if.source             io_op,
    input  logic [`XLEN_W-1:0]       i_alu_result,
    input  logic [`XLEN_W-1:0]       i_pc_next,
    input  logic [`XLEN_W-1:0]       i_link,
    input  logic                     i_pc_load,
    output rapid_pkg::control_s      o_control_signal,
    output logic [`XLEN_W-1:0]       o_rd_output,
    output logic [`XLEN_W-1:0]       o_pc_ext,
    output logic                     o_pc_load,
    output logic                     o_done
);

    import rapid_pkg::*;

    ex_state_t          state;
    ex_state_t          state_next;
    logic               capture;
    logic [`XLEN_W-1:0] cap_rs1;
    logic [`XLEN_W-1:0] cap_rs2;
    logic [`XLEN_W-1:0] cap_imm;
    logic [`XLEN_W-1:0] cap_pc;
    control_s           cap_control;
    logic [`XLEN_W-1:0] rd_value;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    // Ready only counts while waiting, a strobe during execute is lost
    assign capture = (state == EX_WAIT) && i_pipeline_ready;

    always_comb begin
        case (state)
            EX_WAIT:    state_next = capture ? EX_EXECUTE : EX_WAIT;
            EX_EXECUTE: state_next = EX_WAIT;
            default:    state_next = EX_WAIT;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state       <= EX_WAIT;
            cap_control <= '0;
        end else begin
            state <= state_next;
            if (capture) begin
                cap_control <= i_control_signal;
            end
        end
    end

    // Operand capture
    always_ff @(posedge i_clk) begin
        if (capture) begin
            cap_rs1 <= i_rs1;
            cap_rs2 <= i_rs2;
            cap_imm <= i_imm;
            cap_pc  <= i_pc;
        end
    end

    // Both units see the captured instruction
    assign io_op.rs1     = cap_rs1;
    assign io_op.rs2     = cap_rs2;
    assign io_op.imm     = cap_imm;
    assign io_op.pc      = cap_pc;
    assign io_op.control = cap_control;

    //////////////////////////////////////////////////
    // Result merge and output registers
    //////////////////////////////////////////////////

    // Jumps write the link, branches write nothing
    always_comb begin
        if (cap_control.uncond_branch) begin
            rd_value = i_link;
        end else if (cap_control.cond_branch) begin
            rd_value = '0;
        end else begin
            rd_value = i_alu_result;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_rd_output      <= '0;
            o_pc_ext         <= '0;
            o_pc_load        <= 1'b0;
            o_control_signal <= '0;
            o_done           <= 1'b0;
        end else begin
            // Done lasts one cycle, outputs hold until the next result
            o_done <= (state == EX_EXECUTE);
            if (state == EX_EXECUTE) begin
                o_rd_output      <= rd_value;
                o_pc_ext         <= i_pc_next;
                o_pc_load        <= i_pc_load;
                o_control_signal <= cap_control;
            end
        end
    end

endmodule

//--- branch_unit.sv
`include "rv_macros.svh"

module branch_unit (
    ex_operand_if.unit         io_op,
    output logic [`XLEN_W-1:0] o_pc_next,
    output logic               o_pc_load,
    output logic [`XLEN_W-1:0] o_link
);

    import rapid_pkg::*;

    logic [`XLEN_W-1:0]        pc_seq;
    logic [`XLEN_W-1:0]        pc_rel;
    logic [`XLEN_W-1:0]        reg_rel;
    logic signed [`XLEN_W-1:0] rs1_s;
    logic signed [`XLEN_W-1:0] rs2_s;
    logic                      taken;
    br_fn_t                    fn;

    //////////////////////////////////////////////////
    // Candidate targets
    //////////////////////////////////////////////////

    // Fall-through address, also the link value
    assign pc_seq  = io_op.pc + `XLEN_W'(`PC_STEP);
    // Branch and JAL target
    assign pc_rel  = io_op.pc + io_op.imm;
    // JALR target before the low bit is dropped
    assign reg_rel = io_op.rs1 + io_op.imm;

    assign rs1_s = io_op.rs1;
    assign rs2_s = io_op.rs2;

    assign fn = br_fn_t'(io_op.control.fcs_opcode);

    assign o_link = pc_seq;

    //////////////////////////////////////////////////
    // Compare and decide
    //////////////////////////////////////////////////

    always_comb begin
        case (fn)
            BR_BEQ:  taken = (io_op.rs1 == io_op.rs2);
            BR_BNE:  taken = (io_op.rs1 != io_op.rs2);
            BR_BLT:  taken = (rs1_s < rs2_s);
            BR_BGE:  taken = (rs1_s >= rs2_s);
            BR_BLTU: taken = (io_op.rs1 < io_op.rs2);
            BR_BGEU: taken = (io_op.rs1 >= io_op.rs2);
            // Jump codes never take a conditional branch
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (io_op.control.cond_branch) begin
            o_pc_load = taken;
            o_pc_next = taken ? pc_rel : pc_seq;
        end else if (io_op.control.uncond_branch) begin
            // Jumps always redirect
            o_pc_load = 1'b1;
            if (fn == BR_JALR) begin
                o_pc_next = reg_rel;
                o_pc_next[`JALR_MASK_BIT] = 1'b0;
            end else begin
                o_pc_next = pc_rel;
            end
        end else begin
            o_pc_load = 1'b0;
            o_pc_next = pc_seq;
        end
    end

endmodule

//--- int_alu.sv
`include "rv_macros.svh"

module int_alu (
    ex_operand_if.unit         io_op,
    output logic [`XLEN_W-1:0] o_result
);

    import rapid_pkg::*;

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    logic [`XLEN_W-1:0]        op_b;
    logic signed [`XLEN_W-1:0] rs1_s;
    logic signed [`XLEN_W-1:0] op_b_s;
    logic [4:0]                shamt;
    alu_fn_t                   fn;
    logic [`XLEN_W-1:0]        alu_out;

    // Register form takes rs2, every other class takes the immediate
    assign op_b = io_op.control.alu_reg ? io_op.rs2 : io_op.imm;

    // Signed views for SLT and SRA
    assign rs1_s  = io_op.rs1;
    assign op_b_s = op_b;

    // Only the low five bits shift on RV32
    assign shamt = op_b[4:0];

    assign fn = alu_fn_t'(io_op.control.fcs_opcode);

    //////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////

    always_comb begin
        case (fn)
            ALU_ADD_SUB: begin
                // iop selects SUB, register form only in practice
                if (io_op.control.iop) begin
                    alu_out = io_op.rs1 - op_b;
                end else begin
                    alu_out = io_op.rs1 + op_b;
                end
            end
            ALU_SLL: alu_out = io_op.rs1 << shamt;
            ALU_SLT: begin
                alu_out = {{(`XLEN_W-1){1'b0}}, (rs1_s < op_b_s)};
            end
            ALU_SLTU: begin
                // Full-width unsigned compare
                alu_out = {{(`XLEN_W-1){1'b0}}, (io_op.rs1 < op_b)};
            end
            ALU_XOR: alu_out = io_op.rs1 ^ op_b;
            ALU_SRL_SRA: begin
                // Arithmetic shift when iop is set
                if (io_op.control.iop) begin
                    alu_out = rs1_s >>> shamt;
                end else begin
                    alu_out = io_op.rs1 >> shamt;
                end
            end
            ALU_OR:  alu_out = io_op.rs1 | op_b;
            ALU_AND: alu_out = io_op.rs1 & op_b;
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result by category
    //////////////////////////////////////////////////

    always_comb begin
        if (io_op.control.alu_imm || io_op.control.alu_reg) begin
            o_result = alu_out;
        end else if (io_op.control.load_upper_imm) begin
            // LUI passes the positioned immediate, AUIPC adds it to pc
            if (io_op.control.iop) begin
                o_result = op_b;
            end else begin
                o_result = io_op.pc + op_b;
            end
        end else if (io_op.control.mem) begin
            // Effective address, same for loads and stores
            o_result = io_op.rs1 + op_b;
        end else begin
            // Branches and jumps produce no ALU value
            o_result = '0;
        end
    end

endmodule

//--- ex_operand_if.sv
`include "rv_macros.svh"

// Captured instruction, shared by both compute units
interface ex_operand_if;

    import rapid_pkg::*;

    // Source operands from the register file
    logic [`XLEN_W-1:0] rs1;
    logic [`XLEN_W-1:0] rs2;
    // Immediate, already shifted into place by decode
    logic [`XLEN_W-1:0] imm;
    // Address of the instruction itself
    logic [`XLEN_W-1:0] pc;
    // Decoder control word
    control_s           control;

    // Sequencer side, driven from the capture registers
    modport source (
        output rs1, rs2, imm, pc, control
    );

    // Compute unit side, read only
    modport unit (
        input rs1, rs2, imm, pc, control
    );

endinterface

//--- rapid_pkg.sv
package rapid_pkg;

    //////////////////////////////////////////////////
    // Control word handed over by the decoder
    //////////////////////////////////////////////////

    // Category flags are one-hot, exactly one set per instruction
    // fcs_opcode picks the operation inside the category
    // iop flips the operation: SUB, SRA, LUI, store
    typedef struct packed {
        // LUI and AUIPC
        logic       load_upper_imm;
        // JAL and JALR
        logic       uncond_branch;
        // BEQ, BNE, BLT, BGE, BLTU, BGEU
        logic       cond_branch;
        // Loads and stores, address only here
        logic       mem;
        // Register-immediate ALU ops
        logic       alu_imm;
        // Register-register ALU ops
        logic       alu_reg;
        // Function field, decoded by the enums below
        logic [2:0] fcs_opcode;
        logic       iop;
        // Reserved for a later decoder revision
        logic       spare;
    } control_s;

    //////////////////////////////////////////////////
    // Stage state and function codes
    //////////////////////////////////////////////////

    typedef enum logic {
        EX_WAIT    = 1'b0,
        EX_EXECUTE = 1'b1
    } ex_state_t;

    // ALU function codes, same values as funct3
    typedef enum logic [2:0] {
        ALU_ADD_SUB = 3'b000,
        ALU_SLL     = 3'b001,
        ALU_SLT     = 3'b010,
        ALU_SLTU    = 3'b011,
        ALU_XOR     = 3'b100,
        ALU_SRL_SRA = 3'b101,
        ALU_OR      = 3'b110,
        ALU_AND     = 3'b111
    } alu_fn_t;

    // Branch codes, jumps sit in the two codes RV32I leaves free
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_JAL  = 3'b010,
        BR_JALR = 3'b011,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_fn_t;

endpackage

//--- rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

//////////////////////////////////////////////////
// Datapath sizing for the RV32I execute stage
//////////////////////////////////////////////////

// One machine word, operands, pc and results
`define XLEN_W 32

// Sequential pc advance, one 32-bit instruction
`define PC_STEP 4

// Low pc bit that JALR targets always clear
`define JALR_MASK_BIT 0

`endif
